//--- hdl/timer_reg_pkg.sv
// APB bus types and the register address map of the timer unit
// Imported by the register file, the top level and the testbench

package timer_reg_pkg;

   localparam int unsigned APB_ADDR_WIDTH = 12;
   localparam int unsigned APB_DATA_WIDTH = 32;

   typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
   typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

   // Channel configuration
   localparam apb_addr_t CFG_LO_OFS = 12'h000;
   localparam apb_addr_t CFG_HI_OFS = 12'h004;

   // Live counter values, a write loads the counter
   localparam apb_addr_t CNT_LO_OFS = 12'h008;
   localparam apb_addr_t CNT_HI_OFS = 12'h00C;

   // Compare values
   localparam apb_addr_t CMP_LO_OFS = 12'h010;
   localparam apb_addr_t CMP_HI_OFS = 12'h014;

   // Trigger registers, bit 0 acts on lo and bit 1 on hi
   // Both read as zero
   localparam apb_addr_t START_OFS  = 12'h018;  // Sets the channel enable
   localparam apb_addr_t RESET_OFS  = 12'h01C;  // Zeroes counter and prescaler

endpackage : timer_reg_pkg

//--- hdl/timer_cfg_pkg.sv
// Field positions of the CFG_LO and CFG_HI registers and the channel mode
// Used wherever a CFG word is written or decoded

package timer_cfg_pkg;

   // Single bit fields
   localparam int unsigned CFG_EN_BIT       = 0;
   localparam int unsigned CFG_IRQ_EN_BIT   = 2;
   localparam int unsigned CFG_MODE_BIT     = 4;
   localparam int unsigned CFG_PRESC_EN_BIT = 6;
   localparam int unsigned CFG_EVENT_BIT    = 7;   // Count edges of the event input

   // Prescaler value occupies bits 15 to 8
   localparam int unsigned CFG_PRESC_LSB    = 8;

   // Only implemented in CFG_HI
   localparam int unsigned CFG_CASCADE_BIT  = 31;

   // What happens when the counter reaches the compare value
   typedef enum logic {
      MODE_CONTINUOUS = 1'b0,  // Wrap to zero and keep counting
      MODE_ONE_SHOT   = 1'b1   // Stop, enable bit is cleared
   } chan_mode_e;

endpackage : timer_cfg_pkg

//--- hdl/apb_timer_regs.sv
`timescale 1ns/1ns
// APB slave of the timer unit, holds CFG and CMP and turns trigger writes into pulses
// Transfers complete in one access cycle, unmapped addresses answer with pslverr

module apb_timer_regs #(
   parameter int unsigned PRESC_WIDTH = 8
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  timer_reg_pkg::apb_addr_t  paddr_i,
   input  timer_reg_pkg::apb_data_t  pwdata_i,
   output timer_reg_pkg::apb_data_t  prdata_o,
   output logic                      pslverr_o,
   output timer_reg_pkg::apb_data_t  cfg_lo_o,
   output timer_reg_pkg::apb_data_t  cfg_hi_o,
   output timer_reg_pkg::apb_data_t  cmp_lo_o,
   output timer_reg_pkg::apb_data_t  cmp_hi_o,
   output logic [1:0]                start_o,
   output logic [1:0]                clear_o,
   output logic [1:0]                cnt_wr_o,
   output timer_reg_pkg::apb_data_t  cnt_wdata_o,
   input  timer_reg_pkg::apb_data_t  count_lo_i,
   input  timer_reg_pkg::apb_data_t  count_hi_i,
   input  logic [1:0]                enabled_i
);

   import timer_reg_pkg::*;
   import timer_cfg_pkg::*;

   // Writable CFG bits, everything else reads as zero
   localparam apb_data_t PRESC_FIELD =
      ((apb_data_t'(1) << PRESC_WIDTH) - apb_data_t'(1)) << CFG_PRESC_LSB;
   localparam apb_data_t CFG_MASK_LO = (apb_data_t'(1) << CFG_EN_BIT)
                                     | (apb_data_t'(1) << CFG_IRQ_EN_BIT)
                                     | (apb_data_t'(1) << CFG_MODE_BIT)
                                     | (apb_data_t'(1) << CFG_PRESC_EN_BIT)
                                     | (apb_data_t'(1) << CFG_EVENT_BIT)
                                     | PRESC_FIELD;
   localparam apb_data_t CFG_MASK_HI = CFG_MASK_LO | (apb_data_t'(1) << CFG_CASCADE_BIT);

   apb_data_t  cfg_q [2];
   apb_data_t  cmp_q [2];
   logic [1:0] start_q;
   logic [1:0] clear_q;
   logic [1:0] cnt_wr_q;
   apb_data_t  cnt_wdata_q;
   logic       access;
   logic       wr_en;
   logic       addr_hit;
   logic       cnt_sel;
   apb_data_t  rdata;

   assign access  = psel_i & penable_i;   // Access phase of a transfer
   assign wr_en   = access & pwrite_i & addr_hit;
   assign cnt_sel = (paddr_i == CNT_LO_OFS) || (paddr_i == CNT_HI_OFS);

   // Address decode and read mux
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (paddr_i)
         CFG_LO_OFS: rdata = cfg_q[0];
         CFG_HI_OFS: rdata = cfg_q[1];
         CNT_LO_OFS: rdata = count_lo_i;
         CNT_HI_OFS: rdata = count_hi_i;
         CMP_LO_OFS: rdata = cmp_q[0];
         CMP_HI_OFS: rdata = cmp_q[1];
         START_OFS, RESET_OFS: rdata = '0;   // Write only
         default: addr_hit = 1'b0;
      endcase
   end

   assign prdata_o  = rdata;
   assign pslverr_o = access & ~addr_hit;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cfg_q    <= '{default: '0};
         cmp_q    <= '{default: '0};
         start_q  <= '0;
         clear_q  <= '0;
         cnt_wr_q <= '0;
      end else begin
         start_q  <= '0;   // Trigger outputs last one cycle
         clear_q  <= '0;
         cnt_wr_q <= '0;

         // Channel switched itself off after a one-shot match
         for (int i = 0; i < 2; i++) begin
            if (cfg_q[i][CFG_EN_BIT] && !enabled_i[i]) begin
               cfg_q[i][CFG_EN_BIT] <= 1'b0;
            end
         end

         if (wr_en) begin
            case (paddr_i)
               CFG_LO_OFS: cfg_q[0] <= pwdata_i & CFG_MASK_LO;
               CFG_HI_OFS: cfg_q[1] <= pwdata_i & CFG_MASK_HI;
               CNT_LO_OFS: cnt_wr_q[0] <= 1'b1;
               CNT_HI_OFS: cnt_wr_q[1] <= 1'b1;
               CMP_LO_OFS: cmp_q[0] <= pwdata_i;
               CMP_HI_OFS: cmp_q[1] <= pwdata_i;
               START_OFS: begin
                  start_q <= pwdata_i[1:0];
                  // Started channels also show as enabled in CFG
                  for (int i = 0; i < 2; i++) begin
                     if (pwdata_i[i]) begin
                        cfg_q[i][CFG_EN_BIT] <= 1'b1;
                     end
                  end
               end
               RESET_OFS: clear_q <= pwdata_i[1:0];
               default: ;
            endcase
         end
      end
   end

   // Load value travels with the cnt_wr pulse
   always_ff @(posedge clk_i) begin
      if (wr_en && cnt_sel) begin
         cnt_wdata_q <= pwdata_i;
      end
   end

   assign cfg_lo_o    = cfg_q[0];
   assign cfg_hi_o    = cfg_q[1];
   assign cmp_lo_o    = cmp_q[0];
   assign cmp_hi_o    = cmp_q[1];
   assign start_o     = start_q;
   assign clear_o     = clear_q;
   assign cnt_wr_o    = cnt_wr_q;
   assign cnt_wdata_o = cnt_wdata_q;

endmodule : apb_timer_regs

//--- hdl/timer_channel.sv
`timescale 1ns/1ns
// One 32-bit timer channel with prescaler, tick source select, counter and compare
// The top level builds lo and hi from this, hi with the cascade input enabled

module timer_channel #(
   parameter int unsigned PRESC_WIDTH = 8,
   parameter bit          CASCADE_EN  = 1'b0
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  timer_reg_pkg::apb_data_t  cfg_i,
   input  timer_reg_pkg::apb_data_t  cmp_i,
   input  logic                      start_i,
   input  logic                      clear_i,
   input  logic                      cnt_wr_i,
   input  timer_reg_pkg::apb_data_t  cnt_wdata_i,
   input  logic                      stop_i,
   input  logic                      event_i,
   input  logic                      cascade_tick_i,
   output timer_reg_pkg::apb_data_t  count_o,
   output logic                      enabled_o,
   output logic                      match_o
);

   import timer_reg_pkg::*;
   import timer_cfg_pkg::*;

   logic [1:0]             evt_sync_q;   // Input register, then second stage
   logic                   evt_prev_q;
   logic                   evt_edge;
   logic [PRESC_WIDTH-1:0] presc_q;
   logic [PRESC_WIDTH-1:0] presc_val;
   logic                   presc_tick;
   logic                   cascade_sel;
   logic                   clk_src;
   logic                   src_tick;
   logic                   run;
   logic                   tick;
   logic                   hit;
   logic                   expired_q;
   logic                   match_q;
   chan_mode_e             mode;
   apb_data_t              count_q;

   assign presc_val   = cfg_i[CFG_PRESC_LSB +: PRESC_WIDTH];
   assign mode        = chan_mode_e'(cfg_i[CFG_MODE_BIT]);
   assign cascade_sel = CASCADE_EN && cfg_i[CFG_CASCADE_BIT];
   assign clk_src     = ~cascade_sel & ~cfg_i[CFG_EVENT_BIT];
   assign enabled_o   = cfg_i[CFG_EN_BIT] & ~expired_q;
   assign run         = enabled_o & ~stop_i;   // Stop freezes every tick source

   // Rising edges of the event pin
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         evt_sync_q <= '0;
         evt_prev_q <= 1'b0;
      end else begin
         evt_sync_q <= {evt_sync_q[0], event_i};
         evt_prev_q <= evt_sync_q[1];
      end
   end

   assign evt_edge = evt_sync_q[1] & ~evt_prev_q;

   // Prescaler, one tick per presc_val + 1 running cycles
   assign presc_tick = ~cfg_i[CFG_PRESC_EN_BIT] | (presc_q == presc_val);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         presc_q <= '0;
      end else if (clear_i || !cfg_i[CFG_PRESC_EN_BIT]) begin
         presc_q <= '0;
      end else if (run && clk_src) begin
         presc_q <= presc_tick ? '0 : presc_q + 1'b1;
      end
   end

   always_comb begin
      if (cascade_sel) begin
         src_tick = cascade_tick_i;   // Lo match pulse
      end else if (cfg_i[CFG_EVENT_BIT]) begin
         src_tick = evt_edge;
      end else begin
         src_tick = presc_tick;
      end
   end

   assign tick = run & src_tick;
   assign hit  = tick & ~clear_i & ~cnt_wr_i & (count_q == cmp_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_q   <= '0;
         match_q   <= 1'b0;
         expired_q <= 1'b0;
      end else begin
         match_q <= hit;
         if (clear_i) begin
            count_q <= '0;
         end else if (cnt_wr_i) begin
            count_q <= cnt_wdata_i;
         end else if (hit) begin
            if (mode == MODE_CONTINUOUS) begin
               count_q <= '0;
            end   // One-shot holds the compare value
         end else if (tick) begin
            count_q <= count_q + 1'b1;
         end

         // Expiry holds until restarted or CFG enable drops
         if (start_i || !cfg_i[CFG_EN_BIT]) begin
            expired_q <= 1'b0;
         end else if (hit && (mode == MODE_ONE_SHOT)) begin
            expired_q <= 1'b1;
         end
      end
   end

   assign count_o = count_q;
   assign match_o = match_q;

endmodule : timer_channel

//--- hdl/timer_irq_ctrl.sv
`timescale 1ns/1ns
// Interrupt and status outputs of the timer unit
// Match pulses become one-cycle irq pulses when the channel's irq enable is set

module timer_irq_ctrl (
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       match_lo_i,
   input  logic       match_hi_i,
   input  logic [1:0] irq_en_i,    // Bit 0 lo, bit 1 hi
   input  logic [1:0] enabled_i,
   output logic       irq_lo_o,
   output logic       irq_hi_o,
   output logic       busy_o
);

   logic irq_lo_q;
   logic irq_hi_q;
   logic busy_q;

   // One cycle behind the match, never held
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         irq_lo_q <= 1'b0;
         irq_hi_q <= 1'b0;
      end else begin
         irq_lo_q <= match_lo_i & irq_en_i[0];
         irq_hi_q <= match_hi_i & irq_en_i[1];
      end
   end

   // Busy while any channel runs
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         busy_q <= 1'b0;
      end else begin
         busy_q <= |enabled_i;
      end
   end

   assign irq_lo_o = irq_lo_q;
   assign irq_hi_o = irq_hi_q;
   assign busy_o   = busy_q;

endmodule : timer_irq_ctrl

//--- hdl/apb_timer_unit.sv
`timescale 1ns/1ns
// APB timer unit with two 32-bit channels, lo and hi, hi can count lo matches
// Register file feeds both channels, the irq block drives interrupts and busy

module apb_timer_unit #(
   parameter int unsigned PRESC_WIDTH = 8
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  timer_reg_pkg::apb_addr_t  paddr_i,
   input  timer_reg_pkg::apb_data_t  pwdata_i,
   output timer_reg_pkg::apb_data_t  prdata_o,
   output logic                      pslverr_o,
   input  logic                      stoptimer_i,
   input  logic                      event_lo_i,
   input  logic                      event_hi_i,
   output logic                      irq_lo_o,
   output logic                      irq_hi_o,
   output logic                      busy_o
);

   import timer_reg_pkg::*;
   import timer_cfg_pkg::*;

   apb_data_t  cfg_lo;
   apb_data_t  cfg_hi;
   apb_data_t  cmp_lo;
   apb_data_t  cmp_hi;
   apb_data_t  cnt_wdata;
   apb_data_t  count_lo;
   apb_data_t  count_hi;
   logic [1:0] start;      // Bit 0 lo, bit 1 hi
   logic [1:0] clear;
   logic [1:0] cnt_wr;
   logic [1:0] enabled;
   logic       match_lo;
   logic       match_hi;

   apb_timer_regs #(
      .PRESC_WIDTH (PRESC_WIDTH)
   ) i_regs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pslverr_o   (pslverr_o),
      .cfg_lo_o    (cfg_lo),
      .cfg_hi_o    (cfg_hi),
      .cmp_lo_o    (cmp_lo),
      .cmp_hi_o    (cmp_hi),
      .start_o     (start),
      .clear_o     (clear),
      .cnt_wr_o    (cnt_wr),
      .cnt_wdata_o (cnt_wdata),
      .count_lo_i  (count_lo),
      .count_hi_i  (count_hi),
      .enabled_i   (enabled)
   );

   timer_channel #(
      .PRESC_WIDTH (PRESC_WIDTH),
      .CASCADE_EN  (1'b0)
   ) i_chan_lo (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .cfg_i          (cfg_lo),
      .cmp_i          (cmp_lo),
      .start_i        (start[0]),
      .clear_i        (clear[0]),
      .cnt_wr_i       (cnt_wr[0]),
      .cnt_wdata_i    (cnt_wdata),
      .stop_i         (stoptimer_i),
      .event_i        (event_lo_i),
      .cascade_tick_i (1'b0),   // Lo has no cascade source
      .count_o        (count_lo),
      .enabled_o      (enabled[0]),
      .match_o        (match_lo)
   );

   timer_channel #(
      .PRESC_WIDTH (PRESC_WIDTH),
      .CASCADE_EN  (1'b1)
   ) i_chan_hi (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .cfg_i          (cfg_hi),
      .cmp_i          (cmp_hi),
      .start_i        (start[1]),
      .clear_i        (clear[1]),
      .cnt_wr_i       (cnt_wr[1]),
      .cnt_wdata_i    (cnt_wdata),
      .stop_i         (stoptimer_i),
      .event_i        (event_hi_i),
      .cascade_tick_i (match_lo),   // Counts lo compare matches
      .count_o        (count_hi),
      .enabled_o      (enabled[1]),
      .match_o        (match_hi)
   );

   timer_irq_ctrl i_irq (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .match_lo_i (match_lo),
      .match_hi_i (match_hi),
      .irq_en_i   ({cfg_hi[CFG_IRQ_EN_BIT], cfg_lo[CFG_IRQ_EN_BIT]}),
      .enabled_i  (enabled),
      .irq_lo_o   (irq_lo_o),
      .irq_hi_o   (irq_hi_o),
      .busy_o     (busy_o)
   );

endmodule : apb_timer_unit

//--- testbench/apb_timer_unit_chk.sv
`timescale 1ns/1ns
// Concurrent assertions on the APB handshake and the irq pulses of the timer unit
// Bound into apb_timer_unit, every failure also counts up in assert_fail_cnt

module apb_timer_unit_chk (
   input logic                     clk_i,
   input logic                     reset_i,
   input logic                     psel_i,
   input logic                     penable_i,
   input timer_reg_pkg::apb_addr_t paddr_i,
   input logic                     pslverr_i,
   input logic                     irq_lo_i,
   input logic                     irq_hi_i
);

   import timer_reg_pkg::*;

   int unsigned assert_fail_cnt = 0;
   logic        addr_mapped;

   assign addr_mapped = paddr_i inside {CFG_LO_OFS, CFG_HI_OFS, CNT_LO_OFS, CNT_HI_OFS,
                                        CMP_LO_OFS, CMP_HI_OFS, START_OFS, RESET_OFS};

   // Access phase only straight after a setup phase
   penable_after_setup: assert property (@(posedge clk_i) disable iff (reset_i)
      penable_i |-> psel_i && $past(psel_i) && !$past(penable_i))
   else begin
      assert_fail_cnt++;
      $error("penable high without a preceding setup cycle");
   end

   irq_lo_single: assert property (@(posedge clk_i) disable iff (reset_i)
      irq_lo_i |=> !irq_lo_i)
   else begin
      assert_fail_cnt++;
      $error("irq_lo_o held longer than one cycle");
   end

   irq_hi_single: assert property (@(posedge clk_i) disable iff (reset_i)
      irq_hi_i |=> !irq_hi_i)
   else begin
      assert_fail_cnt++;
      $error("irq_hi_o held longer than one cycle");
   end

   // Error response only in the access phase, and only for holes in the map
   pslverr_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
      pslverr_i == (psel_i && penable_i && !addr_mapped))
   else begin
      assert_fail_cnt++;
      $error("pslverr does not match an access to an unmapped address");
   end

endmodule : apb_timer_unit_chk

bind apb_timer_unit apb_timer_unit_chk i_chk (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .paddr_i   (paddr_i),
   .pslverr_i (pslverr_o),
   .irq_lo_i  (irq_lo_o),
   .irq_hi_i  (irq_hi_o)
);

//--- testbench/tb_apb_timer_unit.sv
`timescale 1ns/1ns
// Testbench of the APB timer unit, runs the command script testbench/timer_input.txt
// Inputs change on the falling edge, read data is taken inside the access cycle

module tb_apb_timer_unit;

   import timer_reg_pkg::*;

   localparam string SCRIPT    = "testbench/timer_input.txt";
   localparam int    RESET_CYC = 4;

   logic        clk = 1'b0;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   apb_data_t   pwdata;
   apb_data_t   prdata;
   logic        pslverr;
   logic        stoptimer;
   logic        event_lo;
   logic        event_hi;
   logic        irq_lo;
   logic        irq_hi;
   logic        busy;
   int unsigned irq_lo_cnt  = 0;
   int unsigned irq_hi_cnt  = 0;
   int unsigned err_cnt     = 0;   // Value mismatches
   int unsigned script_errs = 0;
   int unsigned cycle_cnt   = 0;
   int unsigned cycle_limit = 0;
   logic [31:0] lfsr_q      = 32'd74033;

   apb_timer_unit #(
      .PRESC_WIDTH (8)
   ) i_dut (
      .clk_i       (clk),
      .reset_i     (reset),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pslverr_o   (pslverr),
      .stoptimer_i (stoptimer),
      .event_lo_i  (event_lo),
      .event_hi_i  (event_hi),
      .irq_lo_o    (irq_lo),
      .irq_hi_o    (irq_hi),
      .busy_o      (busy)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   // Irq pulses sampled before the edge updates them
   always @(posedge clk) begin
      if (irq_lo) begin
         irq_lo_cnt++;
      end
      if (irq_hi) begin
         irq_hi_cnt++;
      end
   end

   initial begin
      wait (cycle_limit != 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d clock cycles, the command script did not complete",
               cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic check_value(input string what, input apb_data_t got, input apb_data_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
   endfunction

   function automatic int take_bits(input int count);
      int val;
      val = 0;
      for (int i = 0; i < count; i++) begin
         lfsr_q = lfsr_step(lfsr_q);   // One step per bit
         val    = (val << 1) | lfsr_q[0];
      end
      return val;
   endfunction

   // 0 to 3 idle cycles, setup, access; starts and ends on a falling edge
   task automatic apb_transfer(input logic write, input apb_data_t addr,
                               input apb_data_t wdata, output apb_data_t rdata,
                               output logic err);
      repeat (take_bits(2)) @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = apb_addr_t'(addr);
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Time budget from a first pass over the script
   task automatic compute_cycle_limit();
      int    fd;
      int    n;
      int    cmds;
      int    waits;
      string line;
      string cmd;
      cmds  = 0;
      waits = 0;
      fd    = $fopen(SCRIPT, "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if ($sscanf(line, "%s", cmd) == 1 && cmd[0] != "#") begin
               cmds++;
               if (cmd == "D" && $sscanf(line, "%s %d", cmd, n) == 2) begin
                  waits += n;
               end else if (cmd == "E" && $sscanf(line, "%s %d", cmd, n) == 2) begin
                  waits += 5 * n;   // Each event pulse spans 5 cycles
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = 2 * (waits + 10 * cmds) + 2 * RESET_CYC + 20;
   endtask

   task automatic run_command(input string line);
      string     cmd;
      apb_data_t addr;
      apb_data_t data;
      apb_data_t rdata;
      logic      err;
      int        v0;
      int        v1;
      if ($sscanf(line, "%s", cmd) != 1 || cmd[0] == "#") begin
         return;
      end
      if (cmd == "W" && $sscanf(line, "%s %h %h", cmd, addr, data) == 3) begin
         apb_transfer(1'b1, addr, data, rdata, err);
         check_value($sformatf("pslverr of write to %h", addr[11:0]), err, 0);
      end else if (cmd == "R" && $sscanf(line, "%s %h %h", cmd, addr, data) == 3) begin
         apb_transfer(1'b0, addr, '0, rdata, err);
         check_value($sformatf("read of %h", addr[11:0]), rdata, data);
         check_value($sformatf("pslverr of read from %h", addr[11:0]), err, 0);
      end else if (cmd == "X" && $sscanf(line, "%s %h", cmd, addr) == 2) begin
         apb_transfer(1'b1, addr, '1, rdata, err);   // All ones must not land anywhere
         check_value($sformatf("pslverr of write to %h", addr[11:0]), err, 1);
      end else if (cmd == "E" && $sscanf(line, "%s %d", cmd, v0) == 2) begin
         repeat (v0) begin
            event_lo = 1'b1;
            repeat (2) @(negedge clk);
            event_lo = 1'b0;
            repeat (3) @(negedge clk);
         end
      end else if (cmd == "S" && $sscanf(line, "%s %d", cmd, v0) == 2) begin
         stoptimer = v0[0];
      end else if (cmd == "D" && $sscanf(line, "%s %d", cmd, v0) == 2) begin
         repeat (v0) @(negedge clk);
      end else if (cmd == "I" && $sscanf(line, "%s %d %d", cmd, v0, v1) == 3) begin
         check_value("lo irq count", irq_lo_cnt, v0);
         check_value("hi irq count", irq_hi_cnt, v1);
      end else if (cmd == "B" && $sscanf(line, "%s %d", cmd, v0) == 2) begin
         check_value("busy", busy, v0);
      end else begin
         $display("Unknown or malformed command in the script: %s", line);
         script_errs++;
      end
   endtask

   initial begin
      int          fd;
      int          status;
      int unsigned assert_errs;
      string       line;
      reset     = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      stoptimer = 1'b0;
      event_lo  = 1'b0;
      event_hi  = 1'b0;   // Hi event input stays quiet
      compute_cycle_limit();
      repeat (RESET_CYC) @(negedge clk);
      reset = 1'b0;
      fd    = $fopen(SCRIPT, "r");
      if (fd == 0) begin
         $display("Cannot open the command script %s", SCRIPT);
         script_errs++;
      end else begin
         while (!$feof(fd)) begin
            line   = "";
            status = $fgets(line, fd);
            if (status > 0) begin
               run_command(line);
            end
         end
         $fclose(fd);
      end
      repeat (2) @(negedge clk);
      assert_errs = i_dut.i_chk.assert_fail_cnt;
      $display("Summary: %0d value mismatches, %0d assertion failures, %0d script errors",
               err_cnt, assert_errs, script_errs);
      if (err_cnt == 0 && assert_errs == 0 && script_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule : tb_apb_timer_unit

//--- build.f
hdl/timer_reg_pkg.sv
hdl/timer_cfg_pkg.sv
hdl/apb_timer_regs.sv
hdl/timer_channel.sv
hdl/timer_irq_ctrl.sv
hdl/apb_timer_unit.sv
testbench/apb_timer_unit_chk.sv
testbench/tb_apb_timer_unit.sv

//--- Bender.yml
package:
  name: apb_timer_unit

sources:
  # Packages first, then the design from the leaves up
  - files:
      - hdl/timer_reg_pkg.sv
      - hdl/timer_cfg_pkg.sv
      - hdl/apb_timer_regs.sv
      - hdl/timer_channel.sv
      - hdl/timer_irq_ctrl.sv
      - hdl/apb_timer_unit.sv

  # Simulation only
  - target: test
    files:
      - testbench/apb_timer_unit_chk.sv
      - testbench/tb_apb_timer_unit.sv

//--- testbench/timer_input.txt
# Columns: command, then hex address and hex data, or decimal counts
# W addr data, R addr expect, X addr, E pulses, S stop, D cycles, I lo_irqs hi_irqs, B busy
# Register access and error response
R 000 00000000
W 010 0000abcd
R 010 0000abcd
W 014 12345678
R 014 12345678
W 004 0000ff54
R 004 0000ff54
W 004 00000000
W 018 00000000
R 018 00000000
R 01c 00000000
X 020
X 810
R 010 0000abcd
R 004 00000000
# One-shot lo with prescaler 3 and compare 4
W 010 00000004
W 000 00000355
D 60
R 000 00000354
R 008 00000004
I 1 0
B 0
# Event source on lo, stop blocks a further pulse
W 010 0000ffff
W 01c 00000001
R 008 00000000
W 000 00000081
E 5
R 008 00000005
S 1
E 1
R 008 00000005
W 000 00000000
W 01c 00000003
S 0
# Lo continuous with compare 19, hi cascaded counts lo matches
W 004 80000001
W 010 00000013
W 000 00000005
D 110
S 1
I 6 0
R 00c 00000005
# Stop freeze, counter load and counter reset
D 40
R 00c 00000005
B 1
W 008 00000abc
R 008 00000abc
W 00c 00000077
R 00c 00000077
W 01c 00000003
R 008 00000000
R 00c 00000000
W 000 00000000
W 004 00000000
S 0
D 5
B 0
I 6 0
